// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;    // instruction or data word
    typedef logic [31:0] addr_t;    // byte address, word aligned
    typedef logic [31:0] mask_t;    // set bit takes the new wdata bit

    // 4096 bytes of storage
    localparam int MEM_WORDS = 1024;
    localparam int INDEX_W = $clog2(MEM_WORDS);

    // accept at the controller to rdata_valid
    localparam int READ_LATENCY = 2;

    // held read data before the first result
    localparam logic [31:0] IDLE_DATA = 32'hffff_ffff;

    typedef logic [INDEX_W-1:0] index_t;    // word select, addr bits 11:2

    typedef enum logic [1:0] {
        st_wait_cmd,        // ports open for new commands
        st_wait_ready,      // command saved, memory busy
        st_wait_read        // read in flight
    } arb_state_t;

endpackage

`default_nettype wire

// ==== mem_access/mem_access_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_access_ctrl import mem_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,

    input  wire         cmd_start,
    input  wire         cmd_write,
    output logic        cmd_ready,
    input  wire addr_t  addr,
    input  wire word_t  wdata,
    input  wire mask_t  wmask,
    output word_t       rdata,
    output logic        rdata_valid,

    output logic        array_en,
    output logic        array_we,
    output index_t      array_index,
    output word_t       array_wdata,
    input  wire word_t  array_rdata
);

    logic                    accept;
    logic [READ_LATENCY-1:0] rd_pend;       // one bit per read in flight
    word_t                   rd_pipe [READ_LATENCY-1];
    logic                    wb_pending;    // second cycle of a write
    index_t                  wb_index;
    word_t                   wb_wdata;
    mask_t                   wb_wmask;

    // busy only in the cycle after acceptance
    assign cmd_ready = !(rd_pend[0] || wb_pending);
    assign accept    = cmd_start && cmd_ready;

    assign array_en    = accept || wb_pending;
    assign array_we    = wb_pending;
    assign array_index = wb_pending ? wb_index : addr[INDEX_W+1:2];
    assign array_wdata = (array_rdata & ~wb_wmask) | (wb_wdata & wb_wmask);  // old word merge

    assign rdata       = rd_pipe[READ_LATENCY-2];
    assign rdata_valid = rd_pend[READ_LATENCY-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend    <= '0;
            wb_pending <= 1'b0;
        end else begin
            rd_pend    <= {rd_pend[READ_LATENCY-2:0], accept && !cmd_write};
            wb_pending <= accept && cmd_write;
        end
    end

    always_ff @(posedge clk) begin
        rd_pipe[0] <= array_rdata;
        for (int i = 1; i < READ_LATENCY - 1; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        if (accept) begin
            wb_index <= addr[INDEX_W+1:2];
            wb_wdata <= wdata;
            wb_wmask <= wmask;
        end
    end

    // the arbiter only starts a command when ready is high
    a_no_cmd_in_wb: assert property (@(posedge clk) disable iff (!arst_n)
        wb_pending |-> !cmd_start);

endmodule

`default_nettype wire

// ==== mem_access/mem_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_array import mem_pkg::*; (
    input  wire         clk,
    input  wire         en,
    input  wire         we,
    input  wire index_t index,
    input  wire word_t  wdata,
    output word_t       rdata
);

    word_t mem [MEM_WORDS];     // contents survive reset

    // read-first, old word shows up during a write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[index] <= wdata;
            end
            rdata <= mem[index];    // valid one cycle after en
        end
    end

endmodule

`default_nettype wire

// ==== mem_subsystem.f ====
common/mem_pkg.sv
mem_access/mem_array.sv
mem_access/mem_access_ctrl.sv
source/mem_interface.sv
source/mem_subsystem.sv
tb/mem_checker.sv
tb/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_subsystem -f mem_subsystem.f

# the log decides the result, so a failing run must not stop the script here
./obj_dir/Vtb_mem_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q 'All tests passed!' sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

// ==== source/mem_interface.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_interface import mem_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         halt,

    input  wire         inst_start,
    output logic        inst_ready,
    input  wire addr_t  i_addr,
    output word_t       inst,
    output logic        inst_valid,

    input  wire         d_cmd_start,
    input  wire         d_cmd_write,
    output logic        d_cmd_ready,
    input  wire addr_t  d_addr,
    input  wire word_t  wdata,
    input  wire mask_t  wmask,
    output word_t       rdata,
    output logic        rdata_valid,

    output logic        mem_cmd_start,
    output logic        mem_cmd_write,
    input  wire         mem_cmd_ready,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    output mask_t       mem_wmask,
    input  wire word_t  mem_rdata,
    input  wire         mem_rdata_valid
);

    arb_state_t state;
    logic       cmd_is_inst;    // command in flight is a fetch
    logic       save_d_start;   // data command waits behind the fetch
    logic       save_d_write;
    addr_t      save_i_addr;
    addr_t      save_d_addr;
    word_t      save_wdata;
    mask_t      save_wmask;
    word_t      inst_q;
    word_t      rdata_q;

    logic fetch_acc;
    logic data_acc;
    logic read_done;
    logic chain_data;

    assign inst_ready  = (state == st_wait_cmd) && !halt;
    assign d_cmd_ready = (state == st_wait_cmd) && !halt;

    assign fetch_acc  = inst_start && inst_ready;
    assign data_acc   = d_cmd_start && d_cmd_ready;
    assign read_done  = (state == st_wait_read) && mem_rdata_valid;
    assign chain_data = read_done && cmd_is_inst && save_d_start;  // data right behind the fetch

    assign inst_valid  = read_done && cmd_is_inst;
    assign rdata_valid = read_done && !cmd_is_inst;
    assign inst        = inst_valid ? mem_rdata : inst_q;
    assign rdata       = rdata_valid ? mem_rdata : rdata_q;

    always_comb begin
        mem_cmd_start = 1'b0;
        mem_cmd_write = 1'b0;
        mem_addr      = save_d_addr;
        mem_wdata     = save_wdata;
        mem_wmask     = save_wmask;
        case (state)
            st_wait_cmd: begin
                mem_cmd_start = mem_cmd_ready && (fetch_acc || data_acc);
                mem_cmd_write = !fetch_acc && data_acc && d_cmd_write;  // fetch wins
                mem_addr      = fetch_acc ? i_addr : d_addr;
                mem_wdata     = wdata;
                mem_wmask     = wmask;
            end
            st_wait_ready: begin
                mem_cmd_start = mem_cmd_ready;
                mem_cmd_write = !cmd_is_inst && save_d_write;
                mem_addr      = cmd_is_inst ? save_i_addr : save_d_addr;
            end
            st_wait_read: begin
                mem_cmd_start = chain_data && mem_cmd_ready;
                mem_cmd_write = chain_data && save_d_write;
                mem_addr      = (cmd_is_inst && !chain_data) ? save_i_addr : save_d_addr;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= st_wait_cmd;
            cmd_is_inst  <= 1'b0;
            save_d_start <= 1'b0;
            inst_q       <= IDLE_DATA;
            rdata_q      <= IDLE_DATA;
        end else begin
            if (inst_valid)
                inst_q <= mem_rdata;
            if (rdata_valid)
                rdata_q <= mem_rdata;
            case (state)
                st_wait_cmd: begin
                    save_d_start <= data_acc;
                    if (fetch_acc) begin
                        cmd_is_inst <= 1'b1;
                        state       <= mem_cmd_ready ? st_wait_read : st_wait_ready;
                    end else if (data_acc) begin
                        cmd_is_inst <= 1'b0;
                        if (!mem_cmd_ready)
                            state <= st_wait_ready;
                        else if (!d_cmd_write)
                            state <= st_wait_read;  // writes give no response
                    end
                end
                st_wait_ready: begin
                    if (mem_cmd_ready)
                        state <= (!cmd_is_inst && save_d_write) ? st_wait_cmd : st_wait_read;
                end
                st_wait_read: begin
                    if (chain_data) begin
                        cmd_is_inst <= 1'b0;
                        if (!mem_cmd_ready)
                            state <= st_wait_ready;
                        else if (save_d_write)
                            state <= st_wait_cmd;
                    end else if (mem_rdata_valid) begin
                        state <= st_wait_cmd;
                    end
                end
                default: state <= st_wait_cmd;
            endcase
        end
    end

    // saved copy of the port commands
    always_ff @(posedge clk) begin
        if (state == st_wait_cmd) begin
            save_i_addr  <= i_addr;
            save_d_write <= d_cmd_write;
            save_d_addr  <= d_addr;
            save_wdata   <= wdata;
            save_wmask   <= wmask;
        end
    end

    a_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_cmd_start |-> (mem_addr[1:0] == 2'b00));

    // memory only answers a read the arbiter waits for
    a_read_expected: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rdata_valid |-> (state == st_wait_read));

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem import mem_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         halt,

    input  wire         inst_start,
    output logic        inst_ready,
    input  wire addr_t  i_addr,
    output word_t       inst,
    output logic        inst_valid,

    input  wire         d_cmd_start,
    input  wire         d_cmd_write,
    output logic        d_cmd_ready,
    input  wire addr_t  d_addr,
    input  wire word_t  wdata,
    input  wire mask_t  wmask,
    output word_t       rdata,
    output logic        rdata_valid
);

    // arbiter to access controller
    logic   mem_cmd_start;
    logic   mem_cmd_write;
    logic   mem_cmd_ready;
    addr_t  mem_addr;
    word_t  mem_wdata;
    mask_t  mem_wmask;
    word_t  mem_rdata;
    logic   mem_rdata_valid;

    // access controller to array
    logic   array_en;
    logic   array_we;
    index_t array_index;
    word_t  array_wdata;
    word_t  array_rdata;

    mem_interface u_arbiter (
        .clk             (clk),
        .arst_n          (arst_n),
        .halt            (halt),
        .inst_start      (inst_start),
        .inst_ready      (inst_ready),
        .i_addr          (i_addr),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .d_cmd_start     (d_cmd_start),
        .d_cmd_write     (d_cmd_write),
        .d_cmd_ready     (d_cmd_ready),
        .d_addr          (d_addr),
        .wdata           (wdata),
        .wmask           (wmask),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_write   (mem_cmd_write),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    mem_access_ctrl u_access_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_start   (mem_cmd_start),
        .cmd_write   (mem_cmd_write),
        .cmd_ready   (mem_cmd_ready),
        .addr        (mem_addr),
        .wdata       (mem_wdata),
        .wmask       (mem_wmask),
        .rdata       (mem_rdata),
        .rdata_valid (mem_rdata_valid),
        .array_en    (array_en),
        .array_we    (array_we),
        .array_index (array_index),
        .array_wdata (array_wdata),
        .array_rdata (array_rdata)
    );

    mem_array u_array (
        .clk   (clk),
        .en    (array_en),
        .we    (array_we),
        .index (array_index),
        .wdata (array_wdata),
        .rdata (array_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/mem_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_checker import mem_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         inst_valid,
    input  wire word_t  inst,
    input  wire         rdata_valid,
    input  wire word_t  rdata,
    input  wire word_t  exp_inst,
    input  wire word_t  exp_rdata,
    output int          error_count
);

    string cur_test = "none";
    int    pulse_errors = 0;    // valid pulse monitor
    int    held_errors = 0;     // checks called from the testbench
    int    test_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    assign error_count = pulse_errors + held_errors;

    // every returned word is compared at the edge that samples it
    always @(posedge clk) begin
        if (arst_n && inst_valid && (inst !== exp_inst)) begin
            $display("FAILED %s: inst expected %h, actual %h", cur_test, exp_inst, inst);
            pulse_errors++;
        end
        if (arst_n && rdata_valid && (rdata !== exp_rdata)) begin
            $display("FAILED %s: rdata expected %h, actual %h", cur_test, exp_rdata, rdata);
            pulse_errors++;
        end
    end

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = pulse_errors + held_errors;
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAILED %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
            held_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("test %s: %s", cur_test, what);
        held_errors++;
    endtask

    task automatic end_test();
        int errs;
        @(negedge clk);     // last pulse gets compared at the posedge before
        errs = pulse_errors + held_errors - test_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", cur_test, errs);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed,
                 pulse_errors + held_errors);
    endtask

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int TIMEOUT = 50;    // cycles per wait

    logic   clk = 1'b0;
    logic   arst_n;
    logic   halt;
    logic   inst_start;
    logic   inst_ready;
    addr_t  i_addr;
    word_t  inst;
    logic   inst_valid;
    logic   d_cmd_start;
    logic   d_cmd_write;
    logic   d_cmd_ready;
    addr_t  d_addr;
    word_t  wdata;
    mask_t  wmask;
    word_t  rdata;
    logic   rdata_valid;

    word_t  exp_inst;
    word_t  exp_rdata;
    int     error_count;
    int     seed = 32'h25a8;
    bit     timed_out = 1'b0;   // a wait gave up, later waits return at once
    word_t  model [MEM_WORDS];  // what memory should hold

    always #2 clk = ~clk;

    mem_subsystem u_mem_subsystem (
        .clk(clk), .arst_n(arst_n), .halt(halt),
        .inst_start(inst_start), .inst_ready(inst_ready), .i_addr(i_addr),
        .inst(inst), .inst_valid(inst_valid),
        .d_cmd_start(d_cmd_start), .d_cmd_write(d_cmd_write), .d_cmd_ready(d_cmd_ready),
        .d_addr(d_addr), .wdata(wdata), .wmask(wmask),
        .rdata(rdata), .rdata_valid(rdata_valid)
    );

    mem_checker u_checker (
        .clk(clk), .arst_n(arst_n),
        .inst_valid(inst_valid), .inst(inst), .rdata_valid(rdata_valid), .rdata(rdata),
        .exp_inst(exp_inst), .exp_rdata(exp_rdata), .error_count(error_count)
    );

    // each set mask bit takes the new data bit
    function automatic word_t expected_word(input word_t old_word, input word_t new_word,
                                            input mask_t mask);
        word_t w;
        for (int b = 0; b < 32; b++)
            w[b] = mask[b] ? new_word[b] : old_word[b];
        return w;
    endfunction

    function automatic index_t word_index(input addr_t a);
        return a[INDEX_W+1:2];
    endfunction

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic addr_t rand_addr();
        word_t r;
        r = $random(seed);
        return {r[31:INDEX_W+2], 2'b00} & 32'h0000_0ffc;   // word aligned inside 4 KiB
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (!(inst_ready && d_cmd_ready) && !timed_out) begin
            if (n == TIMEOUT) begin
                u_checker.report_problem("timeout: the ports never became ready");
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // counts falling edges since the command was driven
    task automatic wait_valid(input logic for_inst, inout int n);
        int start;
        start = n;
        while (!(for_inst ? inst_valid : rdata_valid) && !timed_out) begin
            if (n - start == TIMEOUT) begin
                u_checker.report_problem(for_inst ? "timeout: no inst_valid after a fetch"
                                                  : "timeout: no rdata_valid after a data read");
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic issue(input logic do_fetch, input addr_t fa, input logic do_data,
                         input logic wr, input addr_t da, input word_t data, input mask_t mask);
        wait_idle();
        if (do_fetch) begin
            exp_inst   = model[word_index(fa)];     // fetch goes first
            inst_start = 1'b1;
            i_addr     = fa;
        end
        if (do_data) begin
            if (wr)
                model[word_index(da)] = expected_word(model[word_index(da)], data, mask);
            else
                exp_rdata = model[word_index(da)];
            d_cmd_start = 1'b1;
            d_cmd_write = wr;
            d_addr      = da;
            wdata       = data;
            wmask       = mask;
        end
        @(negedge clk);
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
    endtask

    initial begin
        addr_t addr_list [8];
        word_t held;
        int    n;

        for (int i = 0; i < MEM_WORDS; i++)
            model[i] = '0;
        arst_n = 1'b0;
        halt = 1'b0;
        inst_start = 1'b0;
        i_addr = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr = '0;
        wdata = '0;
        wmask = '0;
        exp_inst = IDLE_DATA;
        exp_rdata = IDLE_DATA;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        u_checker.start_test("reset_state");
        u_checker.check_word("inst_valid", 0, inst_valid);
        u_checker.check_word("rdata_valid", 0, rdata_valid);
        u_checker.check_word("inst_ready", 1, inst_ready);
        u_checker.check_word("d_cmd_ready", 1, d_cmd_ready);
        u_checker.check_word("inst", IDLE_DATA, inst);
        u_checker.check_word("rdata", IDLE_DATA, rdata);
        u_checker.end_test();

        u_checker.start_test("full_word_write_read");
        for (int i = 0; i < 8; i++) begin
            addr_list[i] = rand_addr();
            issue(1'b0, '0, 1'b1, 1'b1, addr_list[i], rand_word(), '1);
            @(negedge clk);     // let the write-back finish
            issue(1'b0, '0, 1'b1, 1'b0, addr_list[i], '0, '0);
            n = 1;
            wait_valid(1'b0, n);
            u_checker.check_word("read latency", 2, n);
        end
        u_checker.end_test();

        u_checker.start_test("masked_write");
        for (int i = 0; i < 6; i++) begin
            issue(1'b0, '0, 1'b1, 1'b1, addr_list[i], rand_word(), rand_word());
            issue(1'b0, '0, 1'b1, 1'b0, addr_list[i], '0, '0);   // read right behind
            n = 1;
            wait_valid(1'b0, n);
        end
        u_checker.end_test();

        u_checker.start_test("fetch_and_read");
        issue(1'b1, addr_list[0], 1'b1, 1'b0, addr_list[1], '0, '0);
        n = 1;
        wait_valid(1'b1, n);
        u_checker.check_word("inst latency", 2, n);
        wait_valid(1'b0, n);
        u_checker.check_word("rdata latency", 4, n);
        u_checker.check_word("held inst", exp_inst, inst);
        held = exp_inst;
        issue(1'b0, '0, 1'b1, 1'b0, addr_list[2], '0, '0);
        n = 1;
        wait_valid(1'b0, n);
        u_checker.check_word("inst after data read", held, inst);
        held = exp_rdata;
        issue(1'b1, addr_list[3], 1'b0, 1'b0, '0, '0, '0);
        n = 1;
        wait_valid(1'b1, n);
        u_checker.check_word("rdata after fetch", held, rdata);
        u_checker.end_test();

        u_checker.start_test("fetch_and_write");
        issue(1'b1, addr_list[4], 1'b1, 1'b1, addr_list[5], rand_word(), rand_word());
        n = 1;
        wait_valid(1'b1, n);
        u_checker.check_word("inst latency", 2, n);
        issue(1'b1, addr_list[5], 1'b0, 1'b0, '0, '0, '0);  // sees the saved write
        n = 1;
        wait_valid(1'b1, n);
        u_checker.end_test();

        u_checker.start_test("halt");
        wait_idle();
        halt = 1'b1;
        inst_start = 1'b1;
        i_addr = addr_list[6];
        exp_inst = model[word_index(addr_list[6])];
        repeat (8) begin
            @(negedge clk);
            if (inst_ready || d_cmd_ready)
                u_checker.report_problem("a ready output was high during halt");
            if (inst_valid || rdata_valid)
                u_checker.report_problem("a valid pulse occurred during halt");
        end
        halt = 1'b0;
        @(negedge clk);
        inst_start = 1'b0;
        n = 1;
        wait_valid(1'b1, n);
        u_checker.end_test();

        @(negedge clk);
        u_checker.report();
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
